// ==== filelist.f ====
verilog/lim_pkg.sv
verilog/lim_funct_cell.sv
verilog/lim_maxmin_ctrl.sv
verilog/lim_row_decoder.sv
verilog/lim_array.sv
verilog/lim_maxmin_search.sv
verilog/lim_ram_top.sv
sim/lim_ram_assert.sv
sim/lim_ram_tb.sv

// ==== Bender.yml ====
package:
  name: lim_ram

sources:
  - files:
      - verilog/lim_pkg.sv
      - verilog/lim_funct_cell.sv
      - verilog/lim_maxmin_ctrl.sv
      - verilog/lim_row_decoder.sv
      - verilog/lim_array.sv
      - verilog/lim_maxmin_search.sv
      - verilog/lim_ram_top.sv
  - target: simulation
    files:
      - sim/lim_ram_assert.sv
      - sim/lim_ram_tb.sv

// ==== sim/lim_ram_tb.sv ====
module lim_ram_tb import lim_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam int N_OPS      = 700;            // operations of all tests, with margin

    logic       clk_i;
    logic       rst_ni;
    addr_t      addr_a_i;
    word_t      rdata_a_o;
    logic       en_b_i;
    addr_t      addr_b_i;
    word_t      wdata_b_i;
    logic       we_b_i;
    logic [3:0] be_b_i;
    logic       gnt_b_i;
    word_t      rdata_b_o;
    logic       rvalid_b_o;

    logic [7:0]  model_mem [MEM_BYTES];         // reference byte array
    word_t       model_cfg;
    logic        chk_a, chk_b, srch_on, pend_b_vld, pa_vld, init_done;
    word_t       exp_a, exp_b, pend_b, pa_next;
    int          srch_cnt;
    int          err_tb;
    addr_t       last_wr;
    int unsigned rng_state;
    int          total;

    assign gnt_b_i = en_b_i;                    // bus always grants

    lim_ram_top u_lim_ram_top (.*);

    bind lim_ram_top lim_ram_assert u_assert (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .gnt_b_i    (gnt_b_i),
        .rvalid_b_o (rvalid_b_o),
        .rdata_a_o  (rdata_a_o),
        .rdata_b_o  (rdata_b_o),
        .srch_on_i  (lim_ram_tb.srch_on),
        .srch_cnt_i (lim_ram_tb.srch_cnt),
        .chk_a_i    (lim_ram_tb.chk_a),
        .exp_a_i    (lim_ram_tb.exp_a),
        .chk_b_i    (lim_ram_tb.chk_b),
        .exp_b_i    (lim_ram_tb.exp_b)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    // ============================================================
    // random numbers and reference model
    // ============================================================
    function automatic int unsigned next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic addr_t rand_addr();      // any word but the function cell
        int unsigned r;
        r = next_random();
        return addr_t'((r % 255) * 4 + (r >> 30));
    endfunction

    function automatic word_t model_word(int w);
        word_t v;
        for (int b = 0; b < WORD_BYTES; b++) v[8*b +: 8] = model_mem[WORD_BYTES*w + b];
        return v;
    endfunction

    function automatic lim_op_e model_op();
        return (model_cfg[7:0] <= 8'd8) ? lim_op_e'(model_cfg[7:0]) : OP_NONE;
    endfunction

    function automatic word_t logic_result(lim_op_e op, word_t s, word_t m);
        case (op)
            OP_AND:  return s & m;
            OP_OR:   return s | m;
            OP_XOR:  return s ^ m;
            OP_NAND: return ~(s & m);
            OP_NOR:  return ~(s | m);
            OP_XNOR: return ~(s ^ m);
            default: return s;
        endcase
    endfunction

    task automatic store_word(int w, word_t v, logic [3:0] be);
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) model_mem[WORD_BYTES*w + b] = v[8*b +: 8];
        end
    endtask

    // ============================================================
    // bus cycles
    // ============================================================
    task automatic next_cycle();
        int unsigned r;
        @(negedge clk_i);
        chk_b      = pend_b_vld;                // read issued one cycle ago
        exp_b      = pend_b;
        pend_b_vld = 1'b0;
        chk_a      = pa_vld;
        exp_a      = pa_next;
        r          = next_random();
        addr_a_i   = r[0] ? last_wr : addr_t'(r >> 8);
        pa_next    = model_word(addr_a_i[ADDR_WIDTH-1:2]);
        pa_vld     = init_done;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            next_cycle();
            en_b_i = 1'b0;
            we_b_i = 1'b0;
        end
    endtask

    task automatic write_word(addr_t a, word_t d, logic [3:0] be);
        int      w;
        int      n;
        lim_op_e op;
        word_t   v;
        next_cycle();
        {en_b_i, we_b_i, addr_b_i, wdata_b_i, be_b_i} = {1'b1, 1'b1, a, d, be};
        last_wr = a;
        w  = a[ADDR_WIDTH-1:2];
        op = model_op();
        n  = int'(model_cfg[31:8]);
        if (w == MEM_WORDS - 1) begin
            store_word(w, d, be);               // config word, plain store
            model_cfg = d;
        end else begin
            for (int k = 0; k < ((n >= 2) ? n : 1); k++) begin
                v = (op >= OP_AND && op <= OP_XNOR) ? logic_result(op, model_word(w + k), d) : d;
                store_word(w + k, v, (n >= 2) ? 4'hf : be);
            end
        end
    endtask

    task automatic read_word(addr_t a);
        word_t m;
        int    w;
        next_cycle();
        m = next_random();
        w = a[ADDR_WIDTH-1:2];
        {en_b_i, we_b_i, addr_b_i, wdata_b_i, be_b_i} = {1'b1, 1'b0, a, m, 4'hf};
        pend_b     = logic_result((w == MEM_WORDS - 1) ? OP_NONE : model_op(), model_word(w), m);
        pend_b_vld = 1'b1;
    endtask

    task automatic search(addr_t a);
        int    w0;
        int    n;
        word_t best;
        word_t v;
        w0   = a[ADDR_WIDTH-1:2];
        n    = int'(model_cfg[31:8]);
        best = model_word(w0);
        for (int i = 1; i < n; i++) begin
            v = model_word(w0 + i);
            if ((model_op() == OP_MAX) ? (v > best) : (v < best)) best = v;
        end
        next_cycle();
        {en_b_i, we_b_i, addr_b_i, wdata_b_i, be_b_i} = {1'b1, 1'b0, a, next_random(), 4'hf};
        srch_on  = 1'b1;
        srch_cnt = 0;
        do begin                                // request held through the valid cycle
            next_cycle();
            srch_cnt++;
        end while (!rvalid_b_o && srch_cnt < 40);
        if (!rvalid_b_o) begin
            err_tb++;
            $display("MAX/MIN search at %h never raised rvalid_b_o", a);
        end else begin
            pend_b     = best;                  // result lands at the closing edge
            pend_b_vld = 1'b1;
        end
        next_cycle();
        srch_on = 1'b0;
        en_b_i  = 1'b0;
    endtask

    task automatic apply_reset();
        next_cycle();
        en_b_i = 1'b0;
        we_b_i = 1'b0;
        rst_ni = 1'b0;
        idle(2);
        rst_ni    = 1'b1;
        model_cfg = '0;
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        int n;
        int s;
        lim_op_e range_ops [4];
        range_ops = '{OP_NONE, OP_AND, OP_XOR, OP_NAND};
        rst_ni    = 1'b0;
        {en_b_i, we_b_i, addr_b_i, wdata_b_i, be_b_i, addr_a_i} = '0;
        {chk_a, chk_b, srch_on, pend_b_vld, pa_vld, init_done} = '0;
        {exp_a, exp_b, pend_b, pa_next, model_cfg} = '0;
        srch_cnt  = 0;
        err_tb    = 0;
        last_wr   = '0;
        rng_state = 32'ha2f10760;

        apply_reset();
        idle(3);                                // rvalid low without a grant
        for (int w = 0; w < MEM_WORDS - 1; w++) write_word(addr_t'(w * 4), next_random(), 4'hf);
        write_word(LIM_FUNCT_ADDR, '0, 4'hf);
        init_done = 1'b1;

        repeat (60) begin                       // plain traffic
            if (next_random() & 1) write_word(rand_addr(), next_random(), 4'(next_random()));
            else read_word(rand_addr());
        end

        for (int op = 1; op <= 6; op++) begin
            write_word(LIM_FUNCT_ADDR, word_t'(op), 4'hf);
            repeat (8) begin
                if (next_random() & 1) write_word(rand_addr(), next_random(), 4'(next_random()));
                else read_word(rand_addr());
            end
        end

        foreach (range_ops[i]) begin
            n = 2 + next_random() % 8;
            s = next_random() % (256 - n);      // stays below the function cell
            write_word(LIM_FUNCT_ADDR, {24'(n), 8'(range_ops[i])}, 4'hf);
            write_word(addr_t'(s * 4), next_random(), 4'hf);
            write_word(LIM_FUNCT_ADDR, '0, 4'hf);
            for (int k = s - 1; k <= s + n; k++) begin
                if (k >= 0) read_word(addr_t'(k * 4));
            end
        end

        for (int i = 0; i < 6; i++) begin
            n = 2 + next_random() % 39;
            s = next_random() % (256 - n);
            write_word(LIM_FUNCT_ADDR, {24'(n), (i % 2) ? 8'(OP_MIN) : 8'(OP_MAX)}, 4'hf);
            search(addr_t'(s * 4));
        end

        // reset clears the config, reads go back to plain data
        write_word(LIM_FUNCT_ADDR, {24'd5, 8'(OP_XOR)}, 4'hf);
        idle(2);
        apply_reset();
        read_word(rand_addr());
        write_word(rand_addr(), next_random(), 4'hf);
        read_word(last_wr);
        idle(4);

        total = u_lim_ram_top.u_assert.err_rvalid + u_lim_ram_top.u_assert.err_rdata_b
              + u_lim_ram_top.u_assert.err_rdata_a + err_tb;
        $display("errors: rvalid %0d, port B data %0d, port A data %0d, other %0d",
                 u_lim_ram_top.u_assert.err_rvalid, u_lim_ram_top.u_assert.err_rdata_b,
                 u_lim_ram_top.u_assert.err_rdata_a, err_tb);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(N_OPS * 40 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== sim/lim_ram_assert.sv ====
module lim_ram_assert import lim_pkg::*; (
    input logic  clk_i,
    input logic  rst_ni,
    input logic  gnt_b_i,
    input logic  rvalid_b_o,
    input word_t rdata_a_o,
    input word_t rdata_b_o,
    input logic  srch_on_i,                     // MAX/MIN search in flight
    input int    srch_cnt_i,                    // cycles since the start cycle
    input logic  chk_a_i,
    input word_t exp_a_i,
    input logic  chk_b_i,
    input word_t exp_b_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int err_rvalid = 0;
    int err_rdata_b = 0;
    int err_rdata_a = 0;

    // ============================================================
    // port B valid strobe
    // ============================================================
    a_rvalid_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !srch_on_i |-> (rvalid_b_o == gnt_b_i))
    else begin
        err_rvalid++;
        $error("** Error at %0t: rvalid_b_o = %b, expected %b", $time,
               $sampled(rvalid_b_o), $sampled(gnt_b_i));
    end

    // fixed 32 cycle search latency
    a_rvalid_search: assert property (@(posedge clk_i) disable iff (!rst_ni)
        srch_on_i |-> (rvalid_b_o == (srch_cnt_i == 32)))
    else begin
        err_rvalid++;
        $error("** Error at %0t: rvalid_b_o = %b, expected %b (search cycle %0d)", $time,
               $sampled(rvalid_b_o), $sampled(srch_cnt_i == 32), $sampled(srch_cnt_i));
    end

    // ============================================================
    // read data
    // ============================================================
    a_rdata_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
        chk_b_i |-> (rdata_b_o == exp_b_i))
    else begin
        err_rdata_b++;
        $error("** Error at %0t: rdata_b_o = %h, expected %h", $time,
               $sampled(rdata_b_o), $sampled(exp_b_i));
    end

    a_rdata_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        chk_a_i |-> (rdata_a_o == exp_a_i))
    else begin
        err_rdata_a++;
        $error("** Error at %0t: rdata_a_o = %h, expected %h", $time,
               $sampled(rdata_a_o), $sampled(exp_a_i));
    end

endmodule

// ==== verilog/lim_ram_top.sv ====
module lim_ram_top import lim_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,

    // instruction port, read only
    input  addr_t      addr_a_i,
    output word_t      rdata_a_o,

    // data port
    input  logic       en_b_i,
    input  addr_t      addr_b_i,
    input  word_t      wdata_b_i,
    input  logic       we_b_i,
    input  logic [3:0] be_b_i,
    input  logic       gnt_b_i,
    output word_t      rdata_b_o,
    output logic       rvalid_b_o
);

    logic                 en_b;             // effective request, held during a search
    addr_t                addr_b;           // word aligned
    word_t                wdata_b;
    logic                 we_b;
    logic [3:0]           be_b;
    word_t                mask;
    logic                 start;
    logic                 stop;

    logic                 funct_hit;
    lim_op_e              op;
    logic                 maxmin;
    logic                 range_active;
    addr_t                range_end;

    row_lines_t           row_lines;
    logic [MEM_WORDS-1:0] enabled_rows;
    logic [MEM_WORDS-1:0] wired_or;

    lim_maxmin_ctrl u_maxmin_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .en_b_i      (en_b_i),
        .addr_b_i    (addr_b_i),
        .wdata_b_i   (wdata_b_i),
        .we_b_i      (we_b_i),
        .be_b_i      (be_b_i),
        .gnt_b_i     (gnt_b_i),
        .maxmin_i    (maxmin),
        .funct_hit_i (funct_hit),
        .en_o        (en_b),
        .addr_o      (addr_b),
        .wdata_o     (wdata_b),
        .we_o        (we_b),
        .be_o        (be_b),
        .mask_o      (mask),
        .start_o     (start),
        .stop_o      (stop),
        .rvalid_b_o  (rvalid_b_o)
    );

    lim_funct_cell u_funct_cell (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .en_b_i         (en_b),
        .we_b_i         (we_b),
        .addr_b_i       (addr_b),
        .wdata_b_i      (wdata_b),
        .op_o           (op),
        .maxmin_o       (maxmin),
        .funct_hit_o    (funct_hit),
        .range_active_o (range_active),
        .range_end_o    (range_end)
    );

    lim_row_decoder u_row_decoder (
        .addr_i         (addr_b),
        .be_i           (be_b),
        .range_active_i (range_active),
        .range_end_i    (range_end),
        .row_lines_o    (row_lines)
    );

    lim_array u_array (
        .clk_i          (clk_i),
        .en_i           (en_b),
        .we_i           (we_b),
        .op_i           (op),
        .mask_i         (mask),
        .wdata_i        (wdata_b),
        .row_lines_i    (row_lines),
        .maxmin_i       (maxmin),
        .stop_i         (stop),
        .enabled_rows_i (enabled_rows),
        .addr_a_i       (addr_a_i),
        .rdata_a_o      (rdata_a_o),
        .rdata_b_o      (rdata_b_o),
        .wired_or_o     (wired_or)
    );

    lim_maxmin_search u_maxmin_search (
        .clk_i          (clk_i),
        .en_i           (en_b),
        .op_i           (op),
        .start_i        (start),
        .row_lines_i    (row_lines),
        .wired_or_i     (wired_or),
        .enabled_rows_o (enabled_rows)
    );

endmodule

// ==== verilog/lim_maxmin_search.sv ====
module lim_maxmin_search import lim_pkg::*; (
    input  logic                 clk_i,
    input  logic                 en_i,
    input  lim_op_e              op_i,
    input  logic                 start_i,
    input  row_lines_t           row_lines_i,
    input  logic [MEM_WORDS-1:0] wired_or_i,
    output logic [MEM_WORDS-1:0] enabled_rows_o     // next state, seen by the array on stop
);

    logic [MEM_WORDS-1:0] enabled_q;
    logic [MEM_WORDS-1:0] row_res;              // wired-or seen through the enables
    logic [MEM_WORDS-1:0] keep;

    // disabled rows read 0 for MAX and 1 for MIN
    always_comb begin
        if (op_i == OP_MIN) begin
            row_res = wired_or_i | ~enabled_q;
            keep    = enabled_q & ~row_res;     // rows with the bit clear
        end else begin
            row_res = wired_or_i & enabled_q;
            keep    = row_res;                  // rows with the bit set
        end
    end

    always_comb begin
        enabled_rows_o = '0;
        if (en_i) begin
            if (start_i) begin
                for (int w = 0; w < MEM_WORDS; w++) begin
                    enabled_rows_o[w] = |row_lines_i[WORD_BYTES*w +: WORD_BYTES];
                end
            end else if ((op_i == OP_MAX) || (op_i == OP_MIN)) begin
                // uniform bit among candidates, nothing to narrow
                if ((row_res == '0) || (row_res == '1)) begin
                    enabled_rows_o = enabled_q;
                end else begin
                    enabled_rows_o = keep;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        enabled_q <= enabled_rows_o;
    end

endmodule

// ==== verilog/lim_array.sv ====
module lim_array import lim_pkg::*; (
    input  logic                 clk_i,
    input  logic                 en_i,
    input  logic                 we_i,
    input  lim_op_e              op_i,
    input  word_t                mask_i,
    input  word_t                wdata_i,
    input  row_lines_t           row_lines_i,
    input  logic                 maxmin_i,
    input  logic                 stop_i,
    input  logic [MEM_WORDS-1:0] enabled_rows_i,
    input  addr_t                addr_a_i,
    output word_t                rdata_a_o,
    output word_t                rdata_b_o,
    output logic [MEM_WORDS-1:0] wired_or_o
);

    logic [7:0] mem [MEM_BYTES];
    word_t      stored [MEM_WORDS];             // bytes seen as words
    word_t      mem_and [MEM_WORDS];
    word_t      mem_or [MEM_WORDS];
    word_t      mem_xor [MEM_WORDS];
    word_t      mem_in [MEM_WORDS];             // write-in value per word
    word_t      rd_word;
    word_t      sel_word;

    // ============================================================
    // in-array logic
    // ============================================================
    always_comb begin
        for (int w = 0; w < MEM_WORDS; w++) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                stored[w][8*b +: 8] = mem[WORD_BYTES*w + b];
            end
            mem_and[w] = stored[w] & mask_i;
            mem_or[w]  = stored[w] | mask_i;
            mem_xor[w] = stored[w] ^ mask_i;

            // search line only driven while MAX/MIN is configured
            wired_or_o[w] = maxmin_i & (|mem_and[w]);

            case (op_i)
                OP_AND:  mem_in[w] = mem_and[w];
                OP_OR:   mem_in[w] = mem_or[w];
                OP_XOR:  mem_in[w] = mem_xor[w];
                OP_NAND: mem_in[w] = ~mem_and[w];
                OP_NOR:  mem_in[w] = ~mem_or[w];
                OP_XNOR: mem_in[w] = ~mem_xor[w];
                default: mem_in[w] = wdata_i;   // plain store
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && we_i) begin
            for (int i = 0; i < MEM_BYTES; i++) begin
                if (row_lines_i[i]) begin
                    mem[i] <= mem_in[i/WORD_BYTES][8*(i%WORD_BYTES) +: 8];
                end
            end
        end
    end

    // ============================================================
    // read side
    // ============================================================
    always_comb begin
        rd_word  = '0;
        sel_word = '0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            if (|row_lines_i[WORD_BYTES*w +: WORD_BYTES]) begin
                case (op_i)
                    OP_AND:  rd_word = mem_and[w];
                    OP_OR:   rd_word = mem_or[w];
                    OP_XOR:  rd_word = mem_xor[w];
                    OP_NAND: rd_word = ~mem_and[w];
                    OP_NOR:  rd_word = ~mem_or[w];
                    OP_XNOR: rd_word = ~mem_xor[w];
                    default: rd_word = stored[w];
                endcase
            end
            if (enabled_rows_i[w]) begin
                sel_word = stored[w];           // highest survivor wins
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && !we_i) begin
            if ((op_i == OP_MAX) || (op_i == OP_MIN)) begin
                if (stop_i) begin
                    rdata_b_o <= sel_word;
                end
            end else begin
                rdata_b_o <= rd_word;
            end
        end
    end

    // instruction fetch, aligned word every cycle
    always_ff @(posedge clk_i) begin
        rdata_a_o <= stored[addr_a_i[ADDR_WIDTH-1:2]];
    end

endmodule

// ==== verilog/lim_row_decoder.sv ====
module lim_row_decoder import lim_pkg::*; (
    input  addr_t      addr_i,
    input  logic [3:0] be_i,
    input  logic       range_active_i,
    input  addr_t      range_end_i,
    output row_lines_t row_lines_o
);

    logic [MEM_WORDS-1:0] start_mark;
    logic [MEM_WORDS-1:0] end_mark;
    logic [MEM_WORDS-1:0] fill;                 // words inside [start, end)

    // ============================================================
    // start and end markers
    // ============================================================
    always_comb begin
        start_mark = '0;
        end_mark   = '0;
        start_mark[addr_i[ADDR_WIDTH-1:2]] = 1'b1;
        if (range_active_i) begin
            end_mark[range_end_i[ADDR_WIDTH-1:2]] = 1'b1;
        end
    end

    // ============================================================
    // toggle propagation up the word lines
    // ============================================================
    always_comb begin
        fill[0] = start_mark[0];                // an end that wrapped to 0 is ignored
        for (int w = 1; w < MEM_WORDS; w++) begin
            fill[w] = start_mark[w] ^ end_mark[w] ^ fill[w-1];
        end
    end

    // ranges cover full words, single accesses honour byte enables
    always_comb begin
        for (int w = 0; w < MEM_WORDS; w++) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (range_active_i) begin
                    row_lines_o[WORD_BYTES*w + b] = fill[w];
                end else begin
                    row_lines_o[WORD_BYTES*w + b] = start_mark[w] & be_i[b];
                end
            end
        end
    end

endmodule

// ==== verilog/lim_maxmin_ctrl.sv ====
module lim_maxmin_ctrl import lim_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       en_b_i,
    input  addr_t      addr_b_i,
    input  word_t      wdata_b_i,
    input  logic       we_b_i,
    input  logic [3:0] be_b_i,
    input  logic       gnt_b_i,
    input  logic       maxmin_i,
    input  logic       funct_hit_i,
    output logic       en_o,
    output addr_t      addr_o,
    output word_t      wdata_o,
    output logic       we_o,
    output logic [3:0] be_o,
    output word_t      mask_o,
    output logic       start_o,
    output logic       stop_o,
    output logic       rvalid_b_o
);

    logic       busy_q;                         // search in progress
    word_t      cnt_q;                          // one-hot bit under test
    addr_t      addr_q;
    word_t      wdata_q;
    logic [3:0] be_q;
    logic       search_req;

    // a search is always a read, so held en/we are constants
    assign en_o    = busy_q ? 1'b1    : en_b_i;
    assign we_o    = busy_q ? 1'b0    : we_b_i;
    assign addr_o  = busy_q ? addr_q  : {addr_b_i[ADDR_WIDTH-1:2], 2'b00};
    assign wdata_o = busy_q ? wdata_q : wdata_b_i;
    assign be_o    = busy_q ? be_q    : be_b_i;

    assign search_req = en_b_i && !we_b_i && maxmin_i && !funct_hit_i;
    assign start_o    = search_req && gnt_b_i && !busy_q;
    assign stop_o     = cnt_q[0];               // 32nd cycle after start
    assign mask_o     = busy_q ? cnt_q : wdata_o;
    assign rvalid_b_o = (busy_q || search_req) ? stop_o : gnt_b_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_o) begin
            busy_q <= 1'b1;
            cnt_q  <= 32'h8000_0000;            // msb first
        end else if (busy_q) begin
            busy_q <= !stop_o;
            cnt_q  <= cnt_q >> 1;               // empties itself after bit 0
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_o) begin
            addr_q  <= {addr_b_i[ADDR_WIDTH-1:2], 2'b00};
            wdata_q <= wdata_b_i;
            be_q    <= be_b_i;
        end
    end

endmodule

// ==== verilog/lim_funct_cell.sv ====
module lim_funct_cell import lim_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    en_b_i,
    input  logic    we_b_i,
    input  addr_t   addr_b_i,
    input  word_t   wdata_b_i,
    output lim_op_e op_o,
    output logic    maxmin_o,
    output logic    funct_hit_o,
    output logic    range_active_o,
    output addr_t   range_end_o
);

    word_t   cfg_q;                             // opcode in [7:0], range size above
    lim_op_e op_cfg;
    asize_t  asize;

    assign funct_hit_o = (addr_b_i == LIM_FUNCT_ADDR);
    assign asize       = cfg_q[31:8];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q <= '0;
        end else if (en_b_i && we_b_i && funct_hit_o) begin
            cfg_q <= wdata_b_i;                 // array word is written too
        end
    end

    // unknown codes behave like no operation
    always_comb begin
        if (cfg_q[7:0] <= OP_MIN) begin
            op_cfg = lim_op_e'(cfg_q[7:0]);
        end else begin
            op_cfg = OP_NONE;
        end
    end

    // a config access sees a plain memory
    assign op_o           = funct_hit_o ? OP_NONE : op_cfg;
    assign maxmin_o       = (op_cfg == OP_MAX) || (op_cfg == OP_MIN);
    assign range_active_o = en_b_i && (asize != '0) && (asize != 24'd1) && !funct_hit_o;
    assign range_end_o    = addr_b_i + {asize[ADDR_WIDTH-3:0], 2'b00};    // asize words ahead

endmodule

// ==== verilog/lim_pkg.sv ====
package lim_pkg;

    // ============================================================
    // array geometry
    // ============================================================
    localparam int ADDR_WIDTH = 10;                 // byte address bits
    localparam int MEM_BYTES  = 1024;               // 1 KiB byte array
    localparam int MEM_WORDS  = 256;                // 32-bit words
    localparam int WORD_BYTES = 4;                  // bytes per word

    typedef logic [31:0]           word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [23:0]           asize_t;         // range size in words
    typedef logic [MEM_BYTES-1:0]  row_lines_t;     // one word line per byte

    // last word of the array is the function cell
    localparam addr_t LIM_FUNCT_ADDR = 10'h3FC;

    // ============================================================
    // function cell opcodes (low byte of the config word)
    // ============================================================
    typedef enum logic [7:0] {
        OP_NONE = 8'd0,
        OP_AND  = 8'd1,
        OP_OR   = 8'd2,
        OP_XOR  = 8'd3,
        OP_NOR  = 8'd4,
        OP_NAND = 8'd5,
        OP_XNOR = 8'd6,
        OP_MAX  = 8'd7,
        OP_MIN  = 8'd8
    } lim_op_e;

endpackage
